/* common/exec_params.svh */
// Widths of the data word, immediate field and opcode field for the execute unit
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data path word
`define EXEC_DATA_W 32

// Operand 2 immediate field as it arrives from decode
`define EXEC_IMM_W 12

// ALU opcode and condition field
`define EXEC_OP_W 4

`endif

/* common/exec_pkg.sv */
// Package with the data word, flag, opcode, condition, addressing-mode and shift types
`include "exec_params.svh"

package exec_pkg;

  typedef logic [`EXEC_DATA_W-1:0] word_t;

  // N Z C V from the top bit down
  typedef logic [3:0] flags_t;

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  typedef enum logic [`EXEC_OP_W-1:0] {
    OP_AND = 4'd0,
    OP_EOR = 4'd1,
    OP_SUB = 4'd2,   // A - B
    OP_RSB = 4'd3,   // B - A
    OP_ADD = 4'd4,
    OP_ADC = 4'd5,
    OP_SBC = 4'd6,
    OP_RSC = 4'd7,
    OP_ORR = 4'd12,  // 8 to 11 unused
    OP_MOV = 4'd13,
    OP_BIC = 4'd14,
    OP_MVN = 4'd15
  } alu_op_e;

  typedef enum logic [`EXEC_OP_W-1:0] {
    COND_EQ = 4'd0,
    COND_NE = 4'd1,
    COND_CS = 4'd2,
    COND_CC = 4'd3,
    COND_MI = 4'd4,
    COND_PL = 4'd5,
    COND_VS = 4'd6,
    COND_VC = 4'd7,
    COND_HI = 4'd8,
    COND_LS = 4'd9,
    COND_GE = 4'd10,
    COND_LT = 4'd11,
    COND_GT = 4'd12,
    COND_LE = 4'd13,
    COND_AL = 4'd14,
    COND_NV = 4'd15
  } cond_e;

  typedef enum logic [1:0] {
    AM_ROT_IMM   = 2'd0,
    AM_REG       = 2'd1,
    AM_ZEXT_IMM  = 2'd2,
    AM_SHIFT_REG = 2'd3
  } am_e;

  typedef enum logic [1:0] {
    SH_LSL = 2'd0,
    SH_LSR = 2'd1,
    SH_ASR = 2'd2,
    SH_ROR = 2'd3
  } shift_e;

endpackage

/* verilog/op_stage_reg.sv */
// Input stage register holding one operation behind a valid/ready handshake
`include "exec_params.svh"

module op_stage_reg (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  exec_pkg::alu_op_e       alu_op,
  input  exec_pkg::cond_e         cond,
  input  logic                    store_cc,
  input  exec_pkg::am_e           am,
  input  exec_pkg::word_t         operand_a,
  input  exec_pkg::word_t         rm,
  input  logic [`EXEC_IMM_W-1:0]  imm,
  input  logic                    stage_ready,
  output logic                    in_ready,
  output logic                    stage_valid,
  output exec_pkg::alu_op_e       s_alu_op,
  output exec_pkg::cond_e         s_cond,
  output logic                    s_store_cc,
  output exec_pkg::am_e           s_am,
  output exec_pkg::word_t         s_operand_a,
  output exec_pkg::word_t         s_rm,
  output logic [`EXEC_IMM_W-1:0]  s_imm
);
  import exec_pkg::*;

  // Free slot, or the held op leaves this cycle
  assign in_ready = !stage_valid || stage_ready;

  // When the slot frees up it simply takes whatever is offered
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else if (in_ready) begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s_alu_op    <= alu_op;
      s_cond      <= cond;
      s_store_cc  <= store_cc;
      s_am        <= am;
      s_operand_a <= operand_a;
      s_rm        <= rm;
      s_imm       <= imm;
    end
  end

endmodule

/* execute/operand_shifter.sv */
// Second ALU operand from a rotated immediate, Rm, a zero-extended immediate or shifted Rm
`include "exec_params.svh"

module operand_shifter (
  input  exec_pkg::am_e           am,
  input  exec_pkg::word_t         rm,
  input  logic [`EXEC_IMM_W-1:0]  imm,
  output exec_pkg::word_t         operand_b
);
  import exec_pkg::*;

  localparam int W = `EXEC_DATA_W;

  word_t          imm_byte;
  logic [4:0]     rot_amt;
  logic [4:0]     shift_amt;
  shift_e         shift_type;
  logic [2*W-1:0] imm_rot_dbl;
  logic [2*W-1:0] rm_rot_dbl;

  assign imm_byte   = word_t'(imm[7:0]);
  assign rot_amt    = {imm[11:8], 1'b0};   // Twice the rotate field
  assign shift_amt  = imm[11:7];
  assign shift_type = shift_e'(imm[6:5]);

  // Rotate right by shifting a doubled word, low half is the answer
  assign imm_rot_dbl = {imm_byte, imm_byte} >> rot_amt;
  assign rm_rot_dbl  = {rm, rm} >> shift_amt;

  always_comb begin
    case (am)
      AM_ROT_IMM:  operand_b = imm_rot_dbl[W-1:0];
      AM_REG:      operand_b = rm;
      AM_ZEXT_IMM: operand_b = word_t'(imm);
      default: begin
        case (shift_type)
          SH_LSL:  operand_b = rm << shift_amt;
          SH_LSR:  operand_b = rm >> shift_amt;
          SH_ASR:  operand_b = $signed(rm) >>> shift_amt;  // Sign bit fills
          default: operand_b = rm_rot_dbl[W-1:0];           // ROR, zero amount keeps Rm
        endcase
      end
    endcase
  end

endmodule

/* execute/alu.sv */
// Sixteen-opcode ALU with N, Z, C and V generation and ARM carry rules
`include "exec_params.svh"

module alu (
  input  exec_pkg::alu_op_e alu_op,
  input  exec_pkg::word_t   a,
  input  exec_pkg::word_t   b,
  input  exec_pkg::flags_t  flags_in,
  output exec_pkg::word_t   result,
  output exec_pkg::flags_t  flags_out
);
  import exec_pkg::*;

  localparam int W = `EXEC_DATA_W;

  word_t      add_x;
  word_t      add_y;
  logic       add_cin;
  logic       is_arith;
  logic [W:0] add_sum;
  logic       overflow;

  // All arithmetic ops share one adder, subtraction is x + ~y + 1
  always_comb begin
    add_x    = a;
    add_y    = b;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (alu_op)
      OP_SUB: begin
        add_y   = ~b;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = 1'b1;
      end
      OP_ADD: add_cin = 1'b0;
      OP_ADC: add_cin = flags_in[FLAG_C];
      OP_SBC: begin
        add_y   = ~b;                // A - B - !C
        add_cin = flags_in[FLAG_C];
      end
      OP_RSC: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = flags_in[FLAG_C];
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign add_sum  = {1'b0, add_x} + {1'b0, add_y} + {{W{1'b0}}, add_cin};
  // Same-sign addends giving a different-sign sum
  assign overflow = (add_x[W-1] == add_y[W-1]) && (add_sum[W-1] != add_x[W-1]);

  always_comb begin
    case (alu_op)
      OP_AND:  result = a & b;
      OP_EOR:  result = a ^ b;
      OP_SUB,
      OP_RSB,
      OP_ADD,
      OP_ADC,
      OP_SBC,
      OP_RSC:  result = add_sum[W-1:0];
      OP_ORR:  result = a | b;
      OP_MOV:  result = b;
      OP_BIC:  result = a & ~b;
      OP_MVN:  result = ~b;
      default: result = '0;            // Opcodes 8 to 11
    endcase
  end

  always_comb begin
    flags_out         = flags_in;
    flags_out[FLAG_N] = result[W-1];
    flags_out[FLAG_Z] = (result == '0);
    if (is_arith) begin
      flags_out[FLAG_C] = add_sum[W];  // High means no borrow on subtract
      flags_out[FLAG_V] = overflow;
    end
  end

endmodule

/* execute/condition_check.sv */
// ARM condition field evaluation against the N, Z, C and V flags

module condition_check (
  input  exec_pkg::cond_e  cond,
  input  exec_pkg::flags_t flags,
  output logic             cond_pass
);
  import exec_pkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flags[FLAG_N];
  assign z = flags[FLAG_Z];
  assign c = flags[FLAG_C];
  assign v = flags[FLAG_V];

  always_comb begin
    case (cond)
      COND_EQ: cond_pass = z;
      COND_NE: cond_pass = !z;
      COND_CS: cond_pass = c;
      COND_CC: cond_pass = !c;
      COND_MI: cond_pass = n;
      COND_PL: cond_pass = !n;
      COND_VS: cond_pass = v;
      COND_VC: cond_pass = !v;
      COND_HI: cond_pass = c && !z;          // Unsigned higher
      COND_LS: cond_pass = !c || z;
      COND_GE: cond_pass = (n == v);         // Signed compares
      COND_LT: cond_pass = (n != v);
      COND_GT: cond_pass = !z && (n == v);
      COND_LE: cond_pass = z || (n != v);
      COND_AL: cond_pass = 1'b1;
      default: cond_pass = 1'b0;             // NV never executes
    endcase
  end

endmodule

/* verilog/commit_stage.sv */
// Status flag register and output stage register with its handshake

module commit_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             stage_valid,
  input  logic             store_cc,
  input  logic             cond_pass,
  input  exec_pkg::word_t  alu_result,
  input  exec_pkg::flags_t alu_flags,
  input  logic             out_ready,
  output logic             stage_ready,
  output exec_pkg::flags_t psr_flags,
  output logic             out_valid,
  output exec_pkg::word_t  result,
  output logic             executed,
  output exec_pkg::flags_t flags
);
  import exec_pkg::*;

  logic stage_xfer;
  logic flag_we;

  assign stage_ready = !out_valid || out_ready;
  assign stage_xfer  = stage_valid && stage_ready;
  assign flag_we     = stage_xfer && cond_pass && store_cc;

  // PSR moves with the op, so the next one in line sees it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      psr_flags <= '0;
    end else if (flag_we) begin
      psr_flags <= alu_flags;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (stage_ready) begin
      out_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_xfer) begin
      result   <= cond_pass ? alu_result : '0;  // Squashed ops report zero
      executed <= cond_pass;
      flags    <= flag_we ? alu_flags : psr_flags;
    end
  end

endmodule

/* verilog/arm_execute_unit.sv */
// Top level of the execute unit: stage register, shifter, ALU, condition check, commit
`include "exec_params.svh"

module arm_execute_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  exec_pkg::alu_op_e       alu_op,
  input  exec_pkg::cond_e         cond,
  input  logic                    store_cc,
  input  exec_pkg::am_e           am,
  input  exec_pkg::word_t         operand_a,
  input  exec_pkg::word_t         rm,
  input  logic [`EXEC_IMM_W-1:0]  imm,
  output logic                    in_ready,
  output logic                    out_valid,
  output exec_pkg::word_t         result,
  output logic                    executed,
  output exec_pkg::flags_t        flags,
  input  logic                    out_ready
);
  import exec_pkg::*;

  logic                   stage_valid;
  logic                   stage_ready;
  alu_op_e                s_alu_op;
  cond_e                  s_cond;
  logic                   s_store_cc;
  am_e                    s_am;
  word_t                  s_operand_a;
  word_t                  s_rm;
  logic [`EXEC_IMM_W-1:0] s_imm;
  word_t                  operand_b;
  word_t                  alu_result;
  flags_t                 alu_flags;
  flags_t                 psr_flags;
  logic                   cond_pass;

  op_stage_reg op_stage_reg_inst (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .alu_op      (alu_op),
    .cond        (cond),
    .store_cc    (store_cc),
    .am          (am),
    .operand_a   (operand_a),
    .rm          (rm),
    .imm         (imm),
    .stage_ready (stage_ready),
    .in_ready    (in_ready),
    .stage_valid (stage_valid),
    .s_alu_op    (s_alu_op),
    .s_cond      (s_cond),
    .s_store_cc  (s_store_cc),
    .s_am        (s_am),
    .s_operand_a (s_operand_a),
    .s_rm        (s_rm),
    .s_imm       (s_imm)
  );

  operand_shifter operand_shifter_inst (
    .am        (s_am),
    .rm        (s_rm),
    .imm       (s_imm),
    .operand_b (operand_b)
  );

  alu alu_inst (
    .alu_op    (s_alu_op),
    .a         (s_operand_a),
    .b         (operand_b),
    .flags_in  (psr_flags),   // Carry in and kept C, V
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  condition_check condition_check_inst (
    .cond      (s_cond),
    .flags     (psr_flags),
    .cond_pass (cond_pass)
  );

  commit_stage commit_stage_inst (
    .clk         (clk),
    .reset       (reset),
    .stage_valid (stage_valid),
    .store_cc    (s_store_cc),
    .cond_pass   (cond_pass),
    .alu_result  (alu_result),
    .alu_flags   (alu_flags),
    .out_ready   (out_ready),
    .stage_ready (stage_ready),
    .psr_flags   (psr_flags),
    .out_valid   (out_valid),
    .result      (result),
    .executed    (executed),
    .flags       (flags)
  );

endmodule

/* sim/exec_ref_model.svh */
// Reference model functions for the execute unit and the stimulus LFSR
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Polynomial x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic word_t rotate_right(input word_t x, input logic [4:0] n);
  if (n == 5'd0) begin
    return x;
  end else begin
    return (x >> n) | (x << (32 - n));
  end
endfunction

function automatic word_t expected_operand_b(input am_e m, input word_t r,
                                             input logic [11:0] i);
  case (m)
    AM_ROT_IMM:  return rotate_right({24'b0, i[7:0]}, {i[11:8], 1'b0});
    AM_REG:      return r;
    AM_ZEXT_IMM: return {20'b0, i};
    default: begin
      case (i[6:5])
        2'd0:    return r << i[11:7];
        2'd1:    return r >> i[11:7];
        2'd2:    return $signed(r) >>> i[11:7];
        default: return rotate_right(r, i[11:7]);
      endcase
    end
  endcase
endfunction

// Returns {carry, overflow, sum}
function automatic logic [33:0] add_with_carry(input word_t x, input word_t y,
                                               input logic cin);
  logic [32:0] s;
  s = {1'b0, x} + {1'b0, y} + 33'(cin);
  return {s[32], (x[31] == y[31]) && (s[31] != x[31]), s[31:0]};
endfunction

// Returns {no borrow, overflow, difference} of x - y - bw
function automatic logic [33:0] sub_with_borrow(input word_t x, input word_t y,
                                                input logic bw);
  word_t d;
  logic  no_borrow;
  d         = x - y - 32'(bw);
  no_borrow = ({1'b0, x} >= ({1'b0, y} + 33'(bw)));
  return {no_borrow, (x[31] != y[31]) && (d[31] != x[31]), d};
endfunction

// Returns {new flags, result}
function automatic logic [35:0] alu_reference(input alu_op_e op, input word_t a,
                                              input word_t b, input flags_t f);
  logic [33:0] cvr;
  logic        arith;
  word_t       r;
  flags_t      nf;
  arith = 1'b1;
  cvr   = '0;
  case (op)
    OP_SUB:  cvr = sub_with_borrow(a, b, 1'b0);
    OP_RSB:  cvr = sub_with_borrow(b, a, 1'b0);
    OP_ADD:  cvr = add_with_carry(a, b, 1'b0);
    OP_ADC:  cvr = add_with_carry(a, b, f[FLAG_C]);
    OP_SBC:  cvr = sub_with_borrow(a, b, !f[FLAG_C]);
    OP_RSC:  cvr = sub_with_borrow(b, a, !f[FLAG_C]);
    default: arith = 1'b0;
  endcase
  case (op)
    OP_AND:  r = a & b;
    OP_EOR:  r = a ^ b;
    OP_ORR:  r = a | b;
    OP_MOV:  r = b;
    OP_BIC:  r = a & ~b;
    OP_MVN:  r = ~b;
    default: r = arith ? cvr[31:0] : '0;  // Reserved codes give zero
  endcase
  nf         = f;
  nf[FLAG_N] = r[31];
  nf[FLAG_Z] = (r == '0);
  if (arith) begin
    nf[FLAG_C] = cvr[33];
    nf[FLAG_V] = cvr[32];
  end
  return {nf, r};
endfunction

function automatic logic condition_holds(input cond_e c, input flags_t f);
  case (c)
    COND_EQ: return f[FLAG_Z];
    COND_NE: return !f[FLAG_Z];
    COND_CS: return f[FLAG_C];
    COND_CC: return !f[FLAG_C];
    COND_MI: return f[FLAG_N];
    COND_PL: return !f[FLAG_N];
    COND_VS: return f[FLAG_V];
    COND_VC: return !f[FLAG_V];
    COND_HI: return f[FLAG_C] && !f[FLAG_Z];
    COND_LS: return !f[FLAG_C] || f[FLAG_Z];
    COND_GE: return f[FLAG_N] == f[FLAG_V];
    COND_LT: return f[FLAG_N] != f[FLAG_V];
    COND_GT: return !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
    COND_LE: return f[FLAG_Z] || (f[FLAG_N] != f[FLAG_V]);
    COND_AL: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

`endif

/* sim/tb_arm_execute_unit.sv */
// Testbench for the execute unit with LFSR stimulus, scoreboard, assertions and reporting
`include "exec_params.svh"

module tb_arm_execute_unit;
  import exec_pkg::*;

  `include "exec_ref_model.svh"

  localparam int N_RAND_ARITH  = 200;
  localparam int N_BP_OPS      = 300;
  localparam int N_LATENCY_OPS = 16;
  localparam int DRAIN_LIMIT   = 64;
  // Back-pressure ops budgeted at 4 cycles each
  localparam int PLANNED_CYCLES = 20 + 60 + (N_RAND_ARITH + 40) + 2 * 5 * 16
                                  + 4 * N_BP_OPS + N_LATENCY_OPS + 60;
  localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  alu_op_e                alu_op;
  cond_e                  cond;
  logic                   store_cc;
  am_e                    am;
  word_t                  operand_a;
  word_t                  rm;
  logic [`EXEC_IMM_W-1:0] imm;
  logic                   in_ready;
  logic                   out_valid;
  word_t                  result;
  logic                   executed;
  flags_t                 flags;
  logic                   out_ready;

  logic [31:0] lfsr_state;
  logic        rand_ready;     // Random out_ready when set
  logic        check_latency;
  flags_t      model_flags;
  word_t       exp_result_q[$];
  logic        exp_exec_q[$];
  flags_t      exp_flags_q[$];
  int          exp_sample_q[$];
  int          pass_count = 0;
  int          fail_count = 0;
  int          fail_at_start = 0;
  int          sample_idx = 0;
  int          cycle_count = 0;
  int          accepted_count = 0;
  int          retired_count = 0;
  int          accept_tries;

  arm_execute_unit arm_execute_unit_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .alu_op    (alu_op),
    .cond      (cond),
    .store_cc  (store_cc),
    .am        (am),
    .operand_a (operand_a),
    .rm        (rm),
    .imm       (imm),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .result    (result),
    .executed  (executed),
    .flags     (flags),
    .out_ready (out_ready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: no progress after %0d cycles, the DUT stopped responding",
               TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic ready_draw();
    logic [31:0] t;
    if (!rand_ready) begin
      return 1'b1;
    end
    t = rand_bits(1);
    return t[0];
  endfunction

  function automatic logic [11:0] shift_field(input logic [4:0] amt, input shift_e t);
    return {amt, t, 5'b0};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    fail_count++;
  endtask

  // Model runs in acceptance order, so its flags track the PSR
  task automatic record_accept();
    word_t       b;
    logic [35:0] fr;
    logic        pass;
    b    = expected_operand_b(am, rm, imm);
    fr   = alu_reference(alu_op, operand_a, b, model_flags);
    pass = condition_holds(cond, model_flags);
    if (pass && store_cc) begin
      model_flags = fr[35:32];
    end
    exp_result_q.push_back(pass ? fr[31:0] : '0);
    exp_exec_q.push_back(pass);
    exp_flags_q.push_back(model_flags);
    exp_sample_q.push_back(sample_idx);
    accepted_count++;
  endtask

  task automatic check_output();
    word_t  er;
    logic   ee;
    flags_t ef;
    int     es;
    retired_count++;
    if (exp_result_q.size() == 0) begin
      $display("output transfer at %0t with no operation pending, extra result", $time);
      fail_count++;
    end else begin
      er = exp_result_q.pop_front();
      ee = exp_exec_q.pop_front();
      ef = exp_flags_q.pop_front();
      es = exp_sample_q.pop_front();
      assert (result === er) pass_count++;
      else report_mismatch("result", result, er);
      assert (executed === ee) pass_count++;
      else report_mismatch("executed", 32'(executed), 32'(ee));
      assert (flags === ef) pass_count++;
      else report_mismatch("flags", 32'(flags), 32'(ef));
      if (check_latency) begin
        assert (sample_idx - es == 2) pass_count++;
        else report_mismatch("latency", sample_idx - es, 2);
      end
    end
  endtask

  // Inputs settle after the falling edge and hold until the rising one
  always @(negedge clk) begin
    #1;
    sample_idx++;
    if (!reset) begin
      if (in_valid && in_ready) begin
        record_accept();
      end
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  end

  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(result) && $stable(executed)
                                  && $stable(flags))
    else begin
      $display("[ERROR] %0t: output changed while stalled", $time);
      fail_count++;
    end

  ready_when_drained: assert property (@(posedge clk) disable iff (reset)
      (!out_valid || out_ready) |-> in_ready)
    else begin
      $display("[ERROR] %0t: in_ready low with room in the pipeline", $time);
      fail_count++;
    end

  task automatic send_op(input alu_op_e op, input cond_e c, input logic scc,
                         input am_e m, input word_t a, input word_t r,
                         input logic [11:0] i);
    accept_tries = 0;
    do begin
      @(negedge clk);
      in_valid  = 1'b1;
      alu_op    = op;
      cond      = c;
      store_cc  = scc;
      am        = m;
      operand_a = a;
      rm        = r;
      imm       = i;
      out_ready = ready_draw();
      #1;
      accept_tries++;
    end while (!in_ready);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = ready_draw();
  endtask

  // Bounded wait for every accepted op to come out
  task automatic drain();
    int waited;
    waited = 0;
    do begin
      idle_cycle();
      waited++;
    end while (exp_result_q.size() != 0 && waited < DRAIN_LIMIT);
    if (exp_result_q.size() != 0) begin
      $display("%0d operations never came out after %0d idle cycles",
               exp_result_q.size(), DRAIN_LIMIT);
      fail_count++;
    end
    idle_cycle();
  endtask

  task automatic send_reg_op(input alu_op_e op, input word_t a, input word_t b);
    send_op(op, COND_AL, 1'b1, AM_REG, a, b, 12'h0);
  endtask

  task automatic send_mov(input am_e m, input word_t r, input logic [11:0] i);
    send_op(OP_MOV, COND_AL, 1'b1, m, 32'h0, r, i);
  endtask

  task automatic send_random_op(input logic full_random);
    alu_op_e     op;
    cond_e       c;
    logic        scc;
    am_e         m;
    word_t       a;
    word_t       r;
    logic [11:0] i;
    op = alu_op_e'(4'(rand_bits(4)));
    m  = am_e'(2'(rand_bits(2)));
    a  = rand_bits(32);
    r  = rand_bits(32);
    i  = 12'(rand_bits(12));
    c  = COND_AL;
    scc = 1'b1;
    if (full_random) begin
      c   = cond_e'(4'(rand_bits(4)));
      scc = 1'(rand_bits(1));
    end
    send_op(op, c, scc, m, a, r, i);
  endtask

  task automatic report_test(input string name);
    if (fail_count == fail_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, fail_count - fail_at_start);
    end
    fail_at_start = fail_count;
  endtask

  task automatic check_reset_state();
    assert (!out_valid) pass_count++;
    else report_mismatch("out_valid after reset", 32'(out_valid), 0);
    assert (in_ready) pass_count++;
    else report_mismatch("in_ready after reset", 32'(in_ready), 1);
    // Flag conditions stay false while the PSR is zero
    send_op(OP_MOV, COND_AL, 1'b0, AM_ZEXT_IMM, 32'h0, 32'h0, 12'h123);
    send_op(OP_MOV, COND_EQ, 1'b1, AM_ZEXT_IMM, 32'h0, 32'h0, 12'h001);
    send_op(OP_MOV, COND_CS, 1'b1, AM_ZEXT_IMM, 32'h0, 32'h0, 12'h002);
    send_op(OP_MOV, COND_MI, 1'b1, AM_ZEXT_IMM, 32'h0, 32'h0, 12'h003);
    send_op(OP_MOV, COND_VS, 1'b1, AM_ZEXT_IMM, 32'h0, 32'h0, 12'h004);
    drain();
    report_test("reset state");
  endtask

  task automatic sweep_operand_forms();
    am_e         m;
    word_t       r;
    logic [11:0] i;
    send_mov(AM_ROT_IMM, 32'h0, 12'h0FF);
    send_mov(AM_ROT_IMM, 32'h0, 12'h1FF);
    send_mov(AM_ROT_IMM, 32'h0, 12'h4AB);
    send_mov(AM_ROT_IMM, 32'h0, 12'hF80);
    send_mov(AM_REG, 32'hDEADBEEF, 12'h000);
    send_mov(AM_ZEXT_IMM, 32'h0, 12'hABC);
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd4, SH_LSL));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd0, SH_LSL));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd8, SH_LSR));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd12, SH_ASR));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd31, SH_ASR));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd16, SH_ROR));
    send_mov(AM_SHIFT_REG, 32'h80000F01, shift_field(5'd0, SH_ROR));
    for (int k = 0; k < 20; k++) begin
      m = am_e'(2'(rand_bits(2)));
      r = rand_bits(32);
      i = 12'(rand_bits(12));
      send_mov(m, r, i);
    end
    drain();
    report_test("operand forms");
  endtask

  task automatic exercise_arithmetic();
    send_reg_op(OP_ADD, 32'h7FFFFFFF, 32'h1);   // Signed overflow
    send_reg_op(OP_ADD, 32'hFFFFFFFF, 32'h1);   // Carry out, zero
    send_reg_op(OP_SUB, 32'h5, 32'h5);
    send_reg_op(OP_SUB, 32'h3, 32'h5);          // Borrow
    send_reg_op(OP_SUB, 32'h80000000, 32'h1);
    send_reg_op(OP_RSB, 32'h5, 32'h3);
    send_reg_op(OP_ADD, 32'hFFFFFFFF, 32'h1);
    send_reg_op(OP_ADC, 32'h1, 32'h1);          // Takes C from the ADD above
    send_reg_op(OP_ADC, 32'h1, 32'h1);
    send_reg_op(OP_SUB, 32'h0, 32'h1);
    send_reg_op(OP_SBC, 32'hA, 32'h3);
    send_reg_op(OP_SUB, 32'h5, 32'h3);
    send_reg_op(OP_SBC, 32'hA, 32'h3);
    send_reg_op(OP_RSC, 32'h3, 32'hA);
    send_reg_op(OP_SBC, 32'h80000000, 32'h0);
    send_reg_op(alu_op_e'(4'd9), 32'h1234, 32'h5678);
    for (int k = 0; k < N_RAND_ARITH; k++) begin
      send_random_op(1'b0);
    end
    drain();
    report_test("arithmetic and flags");
  endtask

  task automatic prepare_flags(input int p);
    case (p)
      0:       send_reg_op(OP_SUB, 32'h5, 32'h5);
      1:       send_reg_op(OP_SUB, 32'h3, 32'h5);
      2:       send_reg_op(OP_ADD, 32'h7FFFFFFF, 32'h1);
      3:       send_reg_op(OP_ADD, 32'hFFFFFFFF, 32'h2);
      default: send_reg_op(OP_SUB, 32'h80000000, 32'h1);
    endcase
  endtask

  task automatic sweep_conditions();
    alu_op_e op;
    logic    scc;
    word_t   a;
    word_t   r;
    for (int p = 0; p < 5; p++) begin
      for (int c = 0; c < 16; c++) begin
        prepare_flags(p);
        op  = alu_op_e'(4'(rand_bits(4)));
        scc = 1'(rand_bits(1));
        a   = rand_bits(32);
        r   = rand_bits(32);
        send_op(op, cond_e'(4'(c)), scc, AM_REG, a, r, 12'h0);
      end
    end
    drain();
    report_test("conditional execution");
  endtask

  task automatic stress_backpressure();
    int gap;
    rand_ready = 1'b1;
    for (int k = 0; k < N_BP_OPS; k++) begin
      if (rand_bits(2) == 0) begin
        gap = 1 + int'(rand_bits(2) % 3);
        repeat (gap) idle_cycle();
      end
      send_random_op(1'b1);
    end
    drain();
    rand_ready = 1'b0;
    assert (accepted_count == retired_count) pass_count++;
    else begin
      $display("operations lost or duplicated: %0d accepted but %0d delivered",
               accepted_count, retired_count);
      fail_count++;
    end
    report_test("back-pressure and ordering");
  endtask

  task automatic measure_latency();
    check_latency = 1'b1;
    for (int k = 0; k < N_LATENCY_OPS; k++) begin
      send_random_op(1'b1);
      assert (accept_tries == 1) pass_count++;
      else begin
        $display("back-to-back input at %0t waited %0d cycles to be accepted",
                 $time, accept_tries);
        fail_count++;
      end
    end
    drain();
    check_latency = 1'b0;
    report_test("latency and throughput");
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    in_valid      = 1'b0;
    alu_op        = OP_AND;
    cond          = COND_AL;
    store_cc      = 1'b0;
    am            = AM_REG;
    operand_a     = '0;
    rm            = '0;
    imm           = '0;
    out_ready     = 1'b1;
    lfsr_state    = 32'd92508;
    rand_ready    = 1'b0;
    check_latency = 1'b0;
    model_flags   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_reset_state();
    sweep_operand_forms();
    exercise_arithmetic();
    sweep_conditions();
    stress_backpressure();
    measure_latency();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
+incdir+sim
common/exec_pkg.sv
verilog/op_stage_reg.sv
execute/operand_shifter.sv
execute/alu.sv
execute/condition_check.sv
verilog/commit_stage.sv
verilog/arm_execute_unit.sv
sim/tb_arm_execute_unit.sv

/* Bender.yml */
package:
  name: arm_execute_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - verilog/op_stage_reg.sv
      - execute/operand_shifter.sv
      - execute/alu.sv
      - execute/condition_check.sv
      - verilog/commit_stage.sv
      - verilog/arm_execute_unit.sv
  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/tb_arm_execute_unit.sv
